//--- poly_actor_settings.svh
/*
 polynomial actor sizing
 word width, polynomial count, degree and block limits, and the
 bit fields of the command word
*/
`ifndef POLY_ACTOR_SETTINGS_SVH
`define POLY_ACTOR_SETTINGS_SVH

`define POLY_WORD       16   // data, command and status width
`define POLY_COUNT      8    // polynomials held by the store
`define POLY_SEL_W      3    // bits needed to pick one polynomial
`define POLY_MAX_DEG    7    // highest degree STP accepts
`define POLY_DEG_W      3    // bits of a stored degree
`define POLY_ADDR_W     6    // coefficient address, polynomial then term
`define POLY_MAX_BLOCK  8    // largest point count for EVB
`define POLY_ARG_W      5    // width of the arg2 field

// command word fields, the low five bits are ignored
`define CMD_OP_MSB      15
`define CMD_OP_LSB      13
`define CMD_A_MSB       12
`define CMD_A_LSB       10
`define CMD_ARG_MSB     9
`define CMD_ARG_LSB     5

`endif

//--- poly_actor_pkg.sv
/*
 polynomial actor types
 opcodes, firing modes, status codes and controller states
*/
`include "poly_actor_settings.svh"

package poly_actor_pkg;

   // opcode field of a command word, values 5 to 7 are invalid
   typedef enum logic [2:0] {
      GET_COMMAND = 3'd0,
      STP         = 3'd1,
      EVP         = 3'd2,
      EVB         = 3'd3,
      RST         = 3'd4
   } opcode_e;

   // firing mode chosen by the parent scheduler
   typedef enum logic [1:0] {
      SETUP_INSTR = 2'd0,
      INSTR       = 2'd1,
      OUTPUT      = 2'd2
   } mode_e;

   // status word written after the results
   typedef enum logic [`POLY_WORD-1:0] {
      ST_OK         = 'd0,
      ST_BAD_OPCODE = 'd1,
      ST_BAD_ARG    = 'd2,
      ST_NO_POLY    = 'd3
   } status_e;

   // firing controller, one start and one wait state per block
   typedef enum logic [2:0] {
      ST_IDLE,
      ST_DEC_START,
      ST_DEC_WAIT,
      ST_EXEC_START,
      ST_EXEC_WAIT,
      ST_OUT_START,
      ST_OUT_WAIT,
      ST_DONE
   } fsm_state_e;

endpackage

//--- poly_coef_store.sv
/*
 coefficient store
 one word per term of every polynomial with a registered read port,
 plus a degree and a valid bit per polynomial
*/
`include "poly_actor_settings.svh"

module poly_coef_store (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    wr_en,
   input  logic [`POLY_ADDR_W-1:0] wr_addr,
   input  logic [`POLY_WORD-1:0]   wr_data,
   input  logic [`POLY_ADDR_W-1:0] rd_addr,
   output logic [`POLY_WORD-1:0]   rd_q,
   input  logic                    deg_wr,
   input  logic [`POLY_SEL_W-1:0]  poly_sel,
   input  logic [`POLY_DEG_W-1:0]  deg_in,
   input  logic                    clear_all,
   output logic [`POLY_DEG_W-1:0]  deg_out,
   output logic                    valid_out
);

   logic [`POLY_WORD-1:0]  mem [0:(1 << `POLY_ADDR_W)-1];  // address is {poly, term}
   logic [`POLY_DEG_W-1:0] deg_tab [0:`POLY_COUNT-1];
   logic [`POLY_COUNT-1:0] valid_tab;

   always_ff @(posedge clk)
   begin
      if (wr_en)
         mem[wr_addr] <= wr_data;
      rd_q <= mem[rd_addr];   // data shows up one cycle after the address
      if (deg_wr)
         deg_tab[poly_sel] <= deg_in;
   end

   // a polynomial becomes valid once its degree is written
   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
         valid_tab <= '0;
      else if (clear_all)
         valid_tab <= '0;   // RST forgets every polynomial at once
      else if (deg_wr)
         valid_tab[poly_sel] <= 1'b1;
   end

   assign deg_out   = deg_tab[poly_sel];
   assign valid_out = valid_tab[poly_sel];

endmodule

//--- poly_cmd_decode.sv
/*
 command decode
 pops one word from the command FIFO, splits it into opcode, polynomial
 and argument, and classifies it into a status code
*/
`include "poly_actor_settings.svh"

module poly_cmd_decode (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    start_decode,
   input  logic [`POLY_WORD-1:0]   command_in,
   output logic                    rd_command,
   output poly_actor_pkg::opcode_e opcode,
   output logic [`POLY_SEL_W-1:0]  poly_sel,
   output logic [`POLY_ARG_W-1:0]  arg2,
   output poly_actor_pkg::status_e cmd_status,
   output logic                    decode_done
);

   typedef enum logic [1:0] {D_IDLE, D_LATCH, D_DONE} dec_state_e;

   dec_state_e state;

   // range checks only, whether the polynomial exists is left to execute
   function automatic poly_actor_pkg::status_e classify(input logic [2:0] op,
                                                        input logic [`POLY_ARG_W-1:0] arg);
      poly_actor_pkg::status_e st;
      st = poly_actor_pkg::ST_OK;
      case (op)
         poly_actor_pkg::STP:
            if (arg > `POLY_MAX_DEG)
               st = poly_actor_pkg::ST_BAD_ARG;
         poly_actor_pkg::EVB:
            if (arg == '0 || arg > `POLY_MAX_BLOCK)
               st = poly_actor_pkg::ST_BAD_ARG;
         poly_actor_pkg::EVP, poly_actor_pkg::RST:
            st = poly_actor_pkg::ST_OK;
         default:
            st = poly_actor_pkg::ST_BAD_OPCODE;   // GET_COMMAND is not a command either
      endcase
      return st;
   endfunction

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         state      <= D_IDLE;
         opcode     <= poly_actor_pkg::GET_COMMAND;
         poly_sel   <= '0;
         arg2       <= '0;
         cmd_status <= poly_actor_pkg::ST_OK;
      end
      else
      begin
         case (state)
            D_IDLE:
               if (start_decode)
                  state <= D_LATCH;
            D_LATCH:
            begin
               // the head word is taken on the same edge that pops it
               opcode     <= poly_actor_pkg::opcode_e'(command_in[`CMD_OP_MSB:`CMD_OP_LSB]);
               poly_sel   <= command_in[`CMD_A_MSB:`CMD_A_LSB];
               arg2       <= command_in[`CMD_ARG_MSB:`CMD_ARG_LSB];
               cmd_status <= classify(command_in[`CMD_OP_MSB:`CMD_OP_LSB],
                                      command_in[`CMD_ARG_MSB:`CMD_ARG_LSB]);
               state      <= D_DONE;
            end
            default:
               state <= D_IDLE;
         endcase
      end
   end

   assign rd_command  = (state == D_LATCH);
   assign decode_done = (state == D_DONE);   // fields are stable from here on

endmodule

//--- poly_exec.sv
/*
 execute block
 runs the decoded command, STP loads coefficients, EVP and EVB evaluate
 by Horner's rule one coefficient per cycle, RST clears the store
*/
`include "poly_actor_settings.svh"

module poly_exec (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    start_exec,
   input  poly_actor_pkg::opcode_e opcode,
   input  logic [`POLY_SEL_W-1:0]  poly_sel,
   input  logic [`POLY_ARG_W-1:0]  arg2,
   input  poly_actor_pkg::status_e cmd_status,
   input  logic [`POLY_WORD-1:0]   data_in,
   output logic                    rd_data,
   output logic                    wr_en,
   output logic [`POLY_ADDR_W-1:0] wr_addr,
   output logic [`POLY_WORD-1:0]   wr_data,
   output logic [`POLY_ADDR_W-1:0] rd_addr,
   input  logic [`POLY_WORD-1:0]   rd_q,
   output logic                    deg_wr,
   output logic [`POLY_DEG_W-1:0]  deg_in,
   output logic                    clear_all,
   input  logic [`POLY_DEG_W-1:0]  deg_out,
   input  logic                    valid_out,
   output logic                    res_push,
   output logic [`POLY_WORD-1:0]   res_value,
   output logic                    status_load,
   output poly_actor_pkg::status_e status_value,
   output logic                    exec_done
);

   typedef enum logic [2:0] {E_IDLE, E_STP, E_LOADX, E_HORNER, E_FINISH} exec_state_e;

   exec_state_e             state;
   logic [`POLY_DEG_W-1:0]  idx;       // current term, counts down to 0
   logic [`POLY_ARG_W-1:0]  pts;       // points still to evaluate
   logic [`POLY_WORD-1:0]   x_r;
   logic [`POLY_WORD-1:0]   acc;
   logic [`POLY_WORD-1:0]   horner;
   poly_actor_pkg::status_e stat_r;
   logic                    running;   // between start_exec and exec_done
   logic                    cmd_ok;

   assign cmd_ok = (cmd_status == poly_actor_pkg::ST_OK);
   assign horner = acc * x_r + rd_q;   // wraps at the word size

   assign rd_data = (state == E_STP) || (state == E_LOADX);
   assign wr_en   = (state == E_STP);
   assign wr_addr = {poly_sel, idx};   // first data word is c_N
   assign wr_data = data_in;
   assign deg_wr  = (state == E_STP) && (idx == '0);   // degree lands with c_0
   assign deg_in  = arg2[`POLY_DEG_W-1:0];

   // the read is registered, so while one term is summed the next is fetched
   assign rd_addr = (state == E_HORNER) ? {poly_sel, idx - 1'b1} : {poly_sel, idx};

   assign clear_all = (state == E_IDLE) && start_exec && cmd_ok &&
                      (opcode == poly_actor_pkg::RST);

   assign res_push     = (state == E_HORNER) && (idx == '0);
   assign res_value    = horner;
   assign status_load  = (state == E_FINISH);
   assign status_value = stat_r;
   assign exec_done    = (state == E_FINISH);

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         state  <= E_IDLE;
         idx    <= '0;
         pts    <= '0;
         stat_r <= poly_actor_pkg::ST_OK;
      end
      else
      begin
         case (state)
            E_IDLE:
               if (start_exec)
               begin
                  stat_r <= poly_actor_pkg::ST_OK;
                  state  <= E_FINISH;   // errors and RST finish right away
                  if (!cmd_ok)
                     stat_r <= cmd_status;
                  else
                     case (opcode)
                        poly_actor_pkg::STP:
                        begin
                           idx   <= arg2[`POLY_DEG_W-1:0];
                           state <= E_STP;
                        end
                        poly_actor_pkg::EVP, poly_actor_pkg::EVB:
                           if (!valid_out)
                              stat_r <= poly_actor_pkg::ST_NO_POLY;   // no data is read
                           else
                           begin
                              idx   <= deg_out;
                              pts   <= (opcode == poly_actor_pkg::EVP) ? 'd1 : arg2;
                              state <= E_LOADX;
                           end
                        poly_actor_pkg::RST:
                           stat_r <= poly_actor_pkg::ST_OK;
                        default:
                           stat_r <= poly_actor_pkg::ST_BAD_OPCODE;
                     endcase
               end
            E_STP:
            begin
               idx <= idx - 1'b1;
               if (idx == '0)
                  state <= E_FINISH;
            end
            E_LOADX:
               state <= E_HORNER;   // c_N is on its way out of the store
            E_HORNER:
            begin
               idx <= idx - 1'b1;
               if (idx == '0)
               begin
                  pts <= pts - 1'b1;
                  if (pts == 'd1)
                     state <= E_FINISH;
                  else
                  begin
                     idx   <= deg_out;   // next point starts again from c_N
                     state <= E_LOADX;
                  end
               end
            end
            default:
               state <= E_IDLE;
         endcase
      end
   end

   // x and the accumulator are plain datapath registers
   always_ff @(posedge clk)
   begin
      if (state == E_LOADX)
      begin
         x_r <= data_in;
         acc <= '0;   // first step then gives c_N
      end
      else if (state == E_HORNER)
         acc <= horner;
   end

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
         running <= 1'b0;
      else if (exec_done)
         running <= 1'b0;
      else if (start_exec)
         running <= 1'b1;
   end

   // data words are only consumed by a started command that decoded cleanly
   a_rd_data_in_cmd: assert property (@(posedge clk) disable iff (!rst)
      rd_data |-> running && cmd_ok);

endmodule

//--- poly_result_out.sv
/*
 result block
 queues evaluated values and the last status, then on an output
 firing writes the queue and the status word, one per cycle
*/
`include "poly_actor_settings.svh"

module poly_result_out (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    res_push,
   input  logic [`POLY_WORD-1:0]   res_value,
   input  logic                    status_load,
   input  poly_actor_pkg::status_e status_value,
   input  logic                    start_output,
   output logic                    wr_out,
   output logic [`POLY_WORD-1:0]   data_out,
   output logic                    output_done
);

   typedef enum logic [1:0] {O_IDLE, O_STREAM, O_DONE} out_state_e;

   out_state_e                           state;
   logic [`POLY_WORD-1:0]                queue [0:`POLY_MAX_BLOCK-1];
   logic [$clog2(`POLY_MAX_BLOCK+1)-1:0] cnt;   // results waiting
   logic [$clog2(`POLY_MAX_BLOCK+1)-1:0] idx;   // next one to write
   poly_actor_pkg::status_e              status_r;

   always_ff @(posedge clk)
   begin
      if (res_push)
         queue[cnt[$clog2(`POLY_MAX_BLOCK)-1:0]] <= res_value;
   end

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         state    <= O_IDLE;
         cnt      <= '0;
         idx      <= '0;
         status_r <= poly_actor_pkg::ST_OK;   // reported before any command
      end
      else
      begin
         if (status_load)
            status_r <= status_value;
         case (state)
            O_IDLE:
            begin
               if (res_push)
                  cnt <= cnt + 1'b1;
               if (start_output)
               begin
                  idx   <= '0;
                  state <= O_STREAM;
               end
            end
            O_STREAM:
               if (idx == cnt)
               begin
                  cnt   <= '0;   // status goes out this cycle, queue is spent
                  state <= O_DONE;
               end
               else
                  idx <= idx + 1'b1;
            default:
               state <= O_IDLE;
         endcase
      end
   end

   assign wr_out      = (state == O_STREAM);
   assign data_out    = (idx == cnt) ? status_r : queue[idx[$clog2(`POLY_MAX_BLOCK)-1:0]];
   assign output_done = (state == O_DONE);

   // execute may only push between output firings and never past the queue depth
   a_no_push_full: assert property (@(posedge clk) disable iff (!rst)
      res_push |-> (cnt < `POLY_MAX_BLOCK) && (state == O_IDLE));

endmodule

//--- poly_firing_fsm.sv
/*
 firing controller
 on each start from the parent runs decode, execute or output depending
 on the mode, waits for that block and answers with done
*/
module poly_firing_fsm (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  start,
   input  poly_actor_pkg::mode_e mode_in,
   input  logic                  decode_done,
   input  logic                  exec_done,
   input  logic                  output_done,
   output logic                  start_decode,
   output logic                  start_exec,
   output logic                  start_output,
   output logic                  done
);

   poly_actor_pkg::fsm_state_e state;
   poly_actor_pkg::fsm_state_e next_state;

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
         state <= poly_actor_pkg::ST_IDLE;
      else
         state <= next_state;
   end

   always_comb
   begin
      next_state = state;   // wait states hold by default
      case (state)
         poly_actor_pkg::ST_IDLE:
            if (start)
               case (mode_in)
                  poly_actor_pkg::SETUP_INSTR: next_state = poly_actor_pkg::ST_DEC_START;
                  poly_actor_pkg::INSTR:       next_state = poly_actor_pkg::ST_EXEC_START;
                  poly_actor_pkg::OUTPUT:      next_state = poly_actor_pkg::ST_OUT_START;
                  default:                     next_state = poly_actor_pkg::ST_DONE;
               endcase
         poly_actor_pkg::ST_DEC_START:
            next_state = poly_actor_pkg::ST_DEC_WAIT;
         poly_actor_pkg::ST_DEC_WAIT:
            if (decode_done)
               next_state = poly_actor_pkg::ST_DONE;
         poly_actor_pkg::ST_EXEC_START:
            next_state = poly_actor_pkg::ST_EXEC_WAIT;
         poly_actor_pkg::ST_EXEC_WAIT:
            if (exec_done)
               next_state = poly_actor_pkg::ST_DONE;
         poly_actor_pkg::ST_OUT_START:
            next_state = poly_actor_pkg::ST_OUT_WAIT;
         poly_actor_pkg::ST_OUT_WAIT:
            if (output_done)
               next_state = poly_actor_pkg::ST_DONE;
         default:
            next_state = poly_actor_pkg::ST_IDLE;   // ST_DONE lasts one cycle
      endcase
   end

   // block starts are registered, so they fire one cycle after leaving idle
   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         start_decode <= 1'b0;
         start_exec   <= 1'b0;
         start_output <= 1'b0;
      end
      else
      begin
         start_decode <= (state == poly_actor_pkg::ST_DEC_START);
         start_exec   <= (state == poly_actor_pkg::ST_EXEC_START);
         start_output <= (state == poly_actor_pkg::ST_OUT_START);
      end
   end

   assign done = (state == poly_actor_pkg::ST_DONE);

   // the three blocks share the FIFO ports and never run together
   // no start may overlap any block's done pulse either
   a_one_block: assert property (@(posedge clk) disable iff (!rst)
      $onehot0({start_decode, start_exec, start_output, decode_done, exec_done, output_done}));

endmodule

//--- poly_actor_top.sv
/*
 polynomial evaluation actor
 firing controller over the decode, execute and result blocks, with the
 coefficient store between execute and its tables
*/
`include "poly_actor_settings.svh"

module poly_actor_top (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  start,
   input  poly_actor_pkg::mode_e mode_in,
   output logic                  done,
   input  logic [`POLY_WORD-1:0] command_in,
   output logic                  rd_command,
   input  logic [`POLY_WORD-1:0] data_in,
   output logic                  rd_data,
   output logic                  wr_out,
   output logic [`POLY_WORD-1:0] data_out
);

   logic                    start_decode, start_exec, start_output;
   logic                    decode_done, exec_done, output_done;
   poly_actor_pkg::opcode_e opcode;
   logic [`POLY_SEL_W-1:0]  poly_sel;
   logic [`POLY_ARG_W-1:0]  arg2;
   poly_actor_pkg::status_e cmd_status;
   logic                    wr_en, deg_wr, clear_all, valid_out;
   logic [`POLY_ADDR_W-1:0] wr_addr, rd_addr;
   logic [`POLY_WORD-1:0]   wr_data, rd_q;
   logic [`POLY_DEG_W-1:0]  deg_in, deg_out;
   logic                    res_push, status_load;
   logic [`POLY_WORD-1:0]   res_value;
   poly_actor_pkg::status_e status_value;

   poly_firing_fsm u_fsm (
      .clk, .rst, .start, .mode_in, .decode_done, .exec_done, .output_done,
      .start_decode, .start_exec, .start_output, .done);

   poly_cmd_decode u_decode (
      .clk, .rst, .start_decode, .command_in, .rd_command,
      .opcode, .poly_sel, .arg2, .cmd_status, .decode_done);

   poly_exec u_exec (
      .clk, .rst, .start_exec, .opcode, .poly_sel, .arg2, .cmd_status, .data_in,
      .rd_data, .wr_en, .wr_addr, .wr_data, .rd_addr, .rd_q, .deg_wr, .deg_in,
      .clear_all, .deg_out, .valid_out, .res_push, .res_value, .status_load,
      .status_value, .exec_done);

   // the store sees the decoded polynomial directly for its tables
   poly_coef_store u_store (
      .clk, .rst, .wr_en, .wr_addr, .wr_data, .rd_addr, .rd_q, .deg_wr,
      .poly_sel, .deg_in, .clear_all, .deg_out, .valid_out);

   poly_result_out u_result (
      .clk, .rst, .res_push, .res_value, .status_load, .status_value,
      .start_output, .wr_out, .data_out, .output_done);

endmodule

//--- poly_actor_tb.sv
/*
 polynomial actor testbench
 models the command, data and output FIFOs, fires the actor through
 decode, execute and output for directed and random commands, and
 compares every output word with a reference model
*/
`include "poly_actor_settings.svh"

module poly_actor_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int NUM_RANDOM  = 300;
   // three firings, the worst EVB evaluation and some handshake slack per step
   localparam int STEP_CYCLES = 3 * 12 + `POLY_MAX_BLOCK * (`POLY_MAX_DEG + 3) + `POLY_MAX_BLOCK;
   localparam int WATCHDOG_NS = (NUM_RANDOM + 20) * STEP_CYCLES * 20 + 10000;

   logic                  clk = 1'b0;
   logic                  rst;
   logic                  start;
   poly_actor_pkg::mode_e mode_in;
   logic                  done;
   logic [`POLY_WORD-1:0] command_in = '0;
   logic                  rd_command;
   logic [`POLY_WORD-1:0] data_in = '0;
   logic                  rd_data;
   logic                  wr_out;
   logic [`POLY_WORD-1:0] data_out;

   logic [`POLY_WORD-1:0] cmd_q [$];   // command FIFO
   logic [`POLY_WORD-1:0] data_q [$];  // data FIFO
   logic [`POLY_WORD-1:0] out_q [$];   // words written by the actor
   logic [`POLY_WORD-1:0] exp_q [$];   // words the model expects
   logic                  cmd_pend = 1'b0;   // a strobe seen this cycle pops at the edge
   logic                  data_pend = 1'b0;
   int                    data_pops = 0;
   int                    errors = 0;
   int                    checks = 0;
   int                    step = 0;

   // reference model of the stored polynomials
   logic [`POLY_WORD-1:0] coef [0:`POLY_COUNT-1][0:`POLY_MAX_DEG];
   int                    deg [0:`POLY_COUNT-1];
   logic [`POLY_COUNT-1:0] stored = '0;

   poly_actor_top u_dut (
      .clk(clk), .rst(rst), .start(start), .mode_in(mode_in), .done(done),
      .command_in(command_in), .rd_command(rd_command), .data_in(data_in),
      .rd_data(rd_data), .wr_out(wr_out), .data_out(data_out));

   always #10 clk = ~clk;   // 20 ns period

   // FIFO model, everything moves on the falling edge where the DUT is settled
   always @(negedge clk)
   begin
      if (cmd_pend)
      begin
         if (cmd_q.size() == 0)
         begin
            errors++;
            $display("command FIFO was read while it was empty");
         end
         else
            void'(cmd_q.pop_front());
      end
      if (data_pend)
      begin
         data_pops++;   // counted even on underflow so the word count check trips
         if (data_q.size() == 0)
         begin
            errors++;
            $display("data FIFO was read while it was empty");
         end
         else
            void'(data_q.pop_front());
      end
      if (wr_out)
         out_q.push_back(data_out);
      cmd_pend   = rd_command;
      data_pend  = rd_data;
      command_in = (cmd_q.size() != 0) ? cmd_q[0] : '0;   // head of each FIFO
      data_in    = (data_q.size() != 0) ? data_q[0] : '0;
   end

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      checks++;
      if (expected !== actual)
      begin
         errors++;
         $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
      end
   endtask

   // Horner's rule on the model coefficients, highest term first
   function automatic logic [`POLY_WORD-1:0] horner(input int a, input logic [`POLY_WORD-1:0] x);
      logic [`POLY_WORD-1:0] acc;
      int                    i;
      acc = '0;
      for (i = deg[a]; i >= 0; i--)
         acc = acc * x + coef[a][i];   // wraps at the word size
      return acc;
   endfunction

   // one start pulse, then wait for done and make sure it is a single pulse
   task automatic fire(input poly_actor_pkg::mode_e m);
      int pulses;
      @(negedge clk);
      start   = 1'b1;
      mode_in = m;
      @(negedge clk);
      start = 1'b0;
      while (!done)
         @(negedge clk);
      pulses = 1;
      repeat (2)
      begin
         @(negedge clk);
         if (done)
            pulses++;
      end
      check($sformatf("done pulses in mode %0d", m), 1, pulses);
   endtask

   task automatic check_output(input string tag);
      int i;
      check({tag, " word count"}, exp_q.size(), out_q.size());
      for (i = 0; i < exp_q.size() && i < out_q.size(); i++)
         check($sformatf("%s word %0d", tag, i), exp_q[i], out_q[i]);
      exp_q.delete();
      out_q.delete();
   endtask

   // one command through all three firings, with the model run alongside
   task automatic run_cmd(input logic [2:0] op, input logic [2:0] a, input logic [4:0] arg);
      logic [`POLY_WORD-1:0] st;
      logic [`POLY_WORD-1:0] w;
      int                    n_words;
      int                    pops0;
      int                    i;
      string                 tag;
      tag = $sformatf("step %0d op %0d poly %0d arg %0d", step, op, a, arg);
      st  = poly_actor_pkg::ST_OK;
      n_words = 0;
      if (!(op inside {poly_actor_pkg::STP, poly_actor_pkg::EVP,
                       poly_actor_pkg::EVB, poly_actor_pkg::RST}))
         st = poly_actor_pkg::ST_BAD_OPCODE;
      else if (op == poly_actor_pkg::STP && arg > `POLY_MAX_DEG)
         st = poly_actor_pkg::ST_BAD_ARG;
      else if (op == poly_actor_pkg::EVB && (arg == 0 || arg > `POLY_MAX_BLOCK))
         st = poly_actor_pkg::ST_BAD_ARG;
      else if ((op == poly_actor_pkg::EVP || op == poly_actor_pkg::EVB) && !stored[a])
         st = poly_actor_pkg::ST_NO_POLY;
      if (st == poly_actor_pkg::ST_OK && op == poly_actor_pkg::STP)
      begin
         for (i = 0; i <= arg; i++)
         begin
            w = `POLY_WORD'($urandom);
            data_q.push_back(w);
            coef[a][arg - i] = w;   // the first word is the highest term
         end
         deg[a]    = arg;
         stored[a] = 1'b1;
         n_words   = arg + 1;
      end
      else if (st == poly_actor_pkg::ST_OK && op != poly_actor_pkg::RST)
      begin
         n_words = (op == poly_actor_pkg::EVP) ? 1 : arg;
         for (i = 0; i < n_words; i++)
         begin
            w = `POLY_WORD'($urandom);   // one x per point
            data_q.push_back(w);
            exp_q.push_back(horner(a, w));
         end
      end
      else if (st == poly_actor_pkg::ST_OK)
         stored = '0;
      else
      begin
         // decoy words that a rejected command must leave alone
         data_q.push_back(`POLY_WORD'($urandom));
         data_q.push_back(`POLY_WORD'($urandom));
      end
      exp_q.push_back(st);
      cmd_q.push_back({op, a, arg, 5'($urandom)});   // low bits are noise
      pops0 = data_pops;
      fire(poly_actor_pkg::SETUP_INSTR);
      fire(poly_actor_pkg::INSTR);
      fire(poly_actor_pkg::OUTPUT);
      check({tag, " command words left"}, 0, cmd_q.size());   // exactly one word taken
      check({tag, " data words read"}, n_words, data_pops - pops0);
      check_output(tag);
      data_q.delete();
      step++;
   endtask

   initial
   begin
      logic [2:0] op;
      logic [2:0] a;
      logic [4:0] arg;
      int         r;
      int         n;
      void'($urandom(32'h30c48baf));
      rst     = 1'b0;
      start   = 1'b0;
      mode_in = poly_actor_pkg::SETUP_INSTR;
      repeat (4) @(negedge clk);
      rst = 1'b1;
      // nothing may move before the parent fires
      repeat (4)
      begin
         @(negedge clk);
         check("idle outputs", 0, {done, rd_command, rd_data, wr_out});
      end
      fire(poly_actor_pkg::OUTPUT);
      exp_q.push_back(poly_actor_pkg::ST_OK);
      check_output("output before any command");

      run_cmd(poly_actor_pkg::STP, 3'd2, 5'd3);
      run_cmd(poly_actor_pkg::EVP, 3'd2, 5'd0);
      run_cmd(poly_actor_pkg::EVB, 3'd2, 5'd5);
      run_cmd(poly_actor_pkg::EVP, 3'd5, 5'd0);   // never stored
      run_cmd(3'd0, 3'd2, 5'd0);                  // GET_COMMAND is not a command
      run_cmd(3'd6, 3'd2, 5'd1);
      run_cmd(poly_actor_pkg::STP, 3'd2, 5'd9);   // degree too high
      run_cmd(poly_actor_pkg::EVB, 3'd2, 5'd0);
      run_cmd(poly_actor_pkg::EVB, 3'd2, 5'd12);
      run_cmd(poly_actor_pkg::EVP, 3'd2, 5'd0);   // poly 2 survives the rejects
      run_cmd(poly_actor_pkg::STP, 3'd7, 5'd7);
      run_cmd(poly_actor_pkg::EVB, 3'd7, 5'd8);
      run_cmd(poly_actor_pkg::RST, 3'd0, 5'd0);
      run_cmd(poly_actor_pkg::EVP, 3'd2, 5'd0);
      run_cmd(poly_actor_pkg::EVB, 3'd7, 5'd3);

      for (n = 0; n < NUM_RANDOM; n++)
      begin
         r   = $urandom % 16;
         a   = 3'($urandom);
         arg = 5'($urandom);
         if (r < 4)
         begin
            op = poly_actor_pkg::STP;
            if ($urandom % 8 != 0)
               arg = 5'($urandom % 8);   // mostly legal degrees
         end
         else if (r < 8)
            op = poly_actor_pkg::EVP;
         else if (r < 12)
         begin
            op = poly_actor_pkg::EVB;
            if ($urandom % 8 != 0)
               arg = 5'(1 + $urandom % 8);
         end
         else if (r == 12)
            op = poly_actor_pkg::RST;
         else
            op = ($urandom % 2 != 0) ? 3'd0 : 3'(5 + $urandom % 3);
         run_cmd(op, a, arg);
      end

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("timeout: the actor stopped answering, errors so far: %0d", errors);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

//--- poly_actor.f
+incdir+.
poly_actor_pkg.sv
poly_coef_store.sv
poly_cmd_decode.sv
poly_exec.sv
poly_result_out.sv
poly_firing_fsm.sv
poly_actor_top.sv
poly_actor_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compiles the polynomial actor testbench with Verilator and runs it
# the run counts as passed only when the pass line shows up in the output

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
   -f poly_actor.f --top-module poly_actor_tb -o poly_actor_sim &&
./obj_dir/poly_actor_sim | tee /dev/stderr | grep -x "STATUS: PASS" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
